// File: rv_core.f
+incdir+dv
logic/rv_isa_pkg.sv
logic/rv_bus_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_data_bus.sv
logic/rv_core.sv
dv/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "run result: pass" \
    || { echo "run result: fail"; exit 1; }

// File: dv/rv_core_model.svh
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// rv64 encoders, field layout from the isa
function automatic logic [31:0] enc_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                      logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'(OPC_OP)};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'(OPC_STORE)};
endfunction

function automatic logic [31:0] enc_u(logic [6:0] opc, int rd, logic [19:0] imm);
    return {imm, 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_j(int rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'(OPC_JAL)};
endfunction

function automatic logic [31:0] enc_b(int rs1, int rs2, logic [12:0] off);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'b000, off[4:1], off[11], 7'(OPC_BRANCH)};
endfunction

function automatic void emit(logic [31:0] w);
    imem[prog_len] = w;
    prog_len++;
endfunction

// random pool x1..x28
function automatic int rreg();
    return $urandom_range(28, 1);
endfunction

task automatic gen_alu();
    case ($urandom_range(7, 0))
        0: emit(enc_u(OPC_LUI, rreg(), 20'($urandom())));
        1: emit(enc_u(OPC_AUIPC, rreg(), 20'($urandom())));
        2: emit(enc_i(OPC_OP_IMM, F3_ADD, rreg(), rreg(), 12'($urandom())));
        3: emit(enc_i(OPC_OP_IMM, F3_SLL, rreg(), rreg(), {6'b0, 6'($urandom())}));
        4: emit(enc_i(OPC_OP_IMM, F3_SRL, rreg(), rreg(), {6'b0, 6'($urandom())}));
        5: emit(enc_r(F7_STD, rreg(), rreg(), F3_ADD, rreg()));
        6: emit(enc_r(F7_SUB, rreg(), rreg(), F3_ADD, rreg()));
        default: emit(enc_r(F7_STD, rreg(), rreg(), F3_SLT, rreg()));
    endcase
endtask

// all accesses relative to x29, inside the 256 byte data window
task automatic gen_mem();
    case ($urandom_range(3, 0))
        0: emit(enc_i(OPC_LOAD, F3_W, rreg(), 29, 12'(4 * $urandom_range(63, 0))));
        1: emit(enc_i(OPC_LOAD, F3_D, rreg(), 29, 12'(8 * $urandom_range(31, 0))));
        2: emit(enc_s(12'(4 * $urandom_range(63, 0)), rreg(), 29, F3_W));
        default: emit(enc_s(12'(8 * $urandom_range(31, 0)), rreg(), 29, F3_D));
    endcase
endtask

// forward transfers only, skipped slots hold stores
task automatic gen_ctrl();
    int n;
    int ra;
    int rs;
    n  = $urandom_range(2, 1);
    ra = rreg();
    rs = rreg();
    case ($urandom_range(2, 0))
        0: emit(enc_j(rreg(), 21'(4 * (n + 1))));
        1: begin
            // target relative to the auipc one slot back
            emit(enc_u(OPC_AUIPC, ra, 20'h0));
            emit(enc_i(OPC_JALR, 3'b000, rreg(), ra, 12'(8 + 4 * n)));
        end
        default: emit(enc_b(rs, ($urandom_range(1, 0) == 1) ? rs : rreg(), 13'(4 * (n + 1))));
    endcase
    for (int k = 0; k < n; k++) begin
        emit(enc_s(12'(4 * $urandom_range(63, 0)), rreg(), 29, F3_W));
    end
endtask

// kind 0 alu, 1 alu+mem, 2 alu+ctrl, 3 everything
task automatic gen_program(int kind);
    int pick;
    for (int i = 0; i < 1024; i++) begin
        imem[i] = '0;
    end
    prog_len = 0;
    emit(enc_u(OPC_LUI, 29, 20'h1));
    emit(enc_i(OPC_OP_IMM, F3_ADD, 31, 29, 12'h700));
    emit(enc_i(OPC_OP_IMM, F3_ADD, 30, 0, MARKER_VAL));
    for (int n = 0; n < BODY_LEN; n++) begin
        pick = $urandom_range(2, 0);
        if (kind == 0 || (kind == 1 && pick == 2) || (kind == 2 && pick == 1)) pick = 0;
        case (pick)
            0: gen_alu();
            1: gen_mem();
            default: gen_ctrl();
        endcase
    end
    // dump the whole pool
    for (int r = 1; r <= 28; r++) begin
        emit(enc_s(12'(8 * (r - 1)), r, 29, F3_D));
    end
    loop_pc = 64'(prog_len * 4);
    emit(enc_j(0, 21'h0));
    // handler stores the marker and returns
    imem[TRAP_VECTOR[11:2]]     = enc_s(12'h0, 30, 31, F3_W);
    imem[TRAP_VECTOR[11:2] + 1] = MRET_INSTR;
endtask

// instruction-level reference, interrupts not modelled
task automatic run_model();
    logic [63:0] x [0:31];
    logic [31:0] mem [0:1023];
    logic [63:0] pc;
    logic [63:0] nxt;
    logic [63:0] a;
    logic [63:0] sa;
    logic [63:0] v1;
    logic [63:0] v2;
    logic [31:0] w;
    int          rd;
    int          steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 1024; i++) mem[i] = dinit[i];
    exp_w.delete();
    pc    = RESET_PC;
    steps = 0;
    while (pc != loop_pc && steps < 4096) begin
        w   = imem[pc[11:2]];
        rd  = int'(w[11:7]);
        v1  = x[w[19:15]];
        v2  = x[w[24:20]];
        a   = v1 + {{52{w[31]}}, w[31:20]};
        sa  = v1 + {{52{w[31]}}, w[31:25], w[11:7]};
        nxt = pc + 64'd4;
        case (w[6:0])
            OPC_LUI:   x[rd] = {{32{w[31]}}, w[31:12], 12'b0};
            OPC_AUIPC: x[rd] = pc + {{32{w[31]}}, w[31:12], 12'b0};
            OPC_OP_IMM: begin
                if (w[14:12] == 3'b000) x[rd] = a;
                if (w[14:12] == 3'b001) x[rd] = v1 << w[25:20];
                if (w[14:12] == 3'b101) x[rd] = v1 >> w[25:20];
            end
            OPC_OP: begin
                if (w[14:12] == 3'b000) x[rd] = w[30] ? v1 - v2 : v1 + v2;
                if (w[14:12] == 3'b010) x[rd] = ($signed(v1) < $signed(v2)) ? 64'd1 : 64'd0;
            end
            OPC_JAL: begin
                x[rd] = pc + 64'd4;
                nxt   = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR: begin
                x[rd] = pc + 64'd4;
                nxt   = a & ~64'd1;
            end
            OPC_BRANCH: if (v1 == v2) nxt = pc + {{51{w[31]}}, w[31], w[7], w[30:25],
                                                  w[11:8], 1'b0};
            OPC_LOAD: begin
                if (w[14:12] == 3'b010) x[rd] = {{32{mem[a[11:2]][31]}}, mem[a[11:2]]};
                if (w[14:12] == 3'b011) x[rd] = {mem[a[11:2] + 1], mem[a[11:2]]};
            end
            OPC_STORE: begin
                mem[sa[11:2]] = v2[31:0];
                exp_w.push_back({sa[31:0], v2[31:0]});
                if (w[14:12] == 3'b011) begin
                    mem[sa[11:2] + 1] = v2[63:32];
                    exp_w.push_back({sa[31:0] + 32'd4, v2[63:32]});
                end
            end
            default: ;
        endcase
        x[0]  = '0;
        pc    = nxt;
        steps++;
    end
endtask

`endif

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    localparam int          PERIOD      = 100;
    localparam logic [31:0] SEED        = 32'hb384_7005;
    localparam int          BODY_LEN    = 40;
    localparam int          SHORT_WAIT  = 3;
    localparam int          LONG_WAIT   = 12;
    localparam int          SETTLE      = 50;
    localparam logic [11:0] MARKER_VAL  = 12'h5a5;
    localparam logic [63:0] MARKER_ADDR = 64'h1700;
    // preamble, four slots per body step, 28 dumps, loop
    localparam int          MAX_INSTR   = 3 + 4 * BODY_LEN + 29;
    // double access with longest waits plus bubbles
    localparam int          MAX_CPI     = 2 * (LONG_WAIT + 3) + 2;
    localparam int          N_RUNS      = 8;
    localparam longint      WATCHDOG_NS = longint'(N_RUNS) * (MAX_INSTR * MAX_CPI + SETTLE + 8)
                                          * PERIOD;

    logic            clk = 1'b0;
    logic            reset = 1'b0;
    logic            irq = 1'b0;
    logic            irq_ack;
    logic [63:0]     pc;
    logic [31:0]     instr;
    wb_s2m_t         wb_s = '0;
    wb_m2s_t         wb_m;

    // program, data image and expected writes
    logic [31:0]     imem [0:1023];
    logic [31:0]     dinit [0:1023];
    logic [31:0]     dmem [0:1023];
    int              prog_len;
    logic [63:0]     loop_pc;
    logic [63:0]     exp_w [$];
    logic [63:0]     got_w [$];

    // slave and irq driver state
    int              max_wait = SHORT_WAIT;
    int              irq_at = -1;
    int              cyc_cnt;
    int              ack_cnt;
    int              marker_cnt;
    int              bus_err;
    int              sel_err;
    logic [BUS_SEL_W-1:0] sel_bad;
    logic            busy;
    int              wait_q;
    wb_m2s_t         hold;

    int              n_tests;
    int              n_failed;
    int              n_errs;
    string           kind_name [0:3] = '{"arith", "ldst", "ctrl", "irq"};

    `include "rv_core_model.svh"

    rv_core u_rv_core (
        .clk       (clk),
        .reset     (reset),
        .instr_i   (instr),
        .irq_i     (irq),
        .wb_i      (wb_s),
        .pc_o      (pc),
        .irq_ack_o (irq_ack),
        .wb_o      (wb_m)
    );

    always #(PERIOD / 2) clk = ~clk;

    // same-cycle instruction memory
    assign instr = imem[pc[11:2]];

    // wishbone slave, random waits before each ack
    always @(posedge clk) begin : wb_slave
        int left;
        if (!reset) begin
            wb_s       <= '0;
            busy       <= 1'b0;
            bus_err    <= 0;
            sel_err    <= 0;
            marker_cnt <= 0;
            got_w.delete();
            for (int i = 0; i < 1024; i++) dmem[i] = dinit[i];
        end else if (wb_s.ack) begin
            wb_s.ack <= 1'b0;
            busy     <= 1'b0;
        end else if (wb_m.cyc && wb_m.stb) begin
            left = wait_q;
            // every word access uses all four lanes
            if (wb_m.sel != {BUS_SEL_W{1'b1}}) begin
                sel_err <= sel_err + 1;
                sel_bad <= wb_m.sel;
            end
            if (!busy) begin
                busy <= 1'b1;
                hold <= wb_m;
                left = $urandom_range(max_wait, 0);
            end else if (wb_m.adr != hold.adr || wb_m.dat != hold.dat || wb_m.we != hold.we) begin
                $display("bus request changed before ack at %0t", $time);
                bus_err <= bus_err + 1;
            end
            if (left == 0) begin
                wb_s.ack <= 1'b1;
                if (wb_m.we) begin
                    dmem[wb_m.adr[11:2]] = wb_m.dat;
                    if (wb_m.adr == MARKER_ADDR) marker_cnt <= marker_cnt + 1;
                    else got_w.push_back({wb_m.adr[31:0], wb_m.dat});
                end else begin
                    wb_s.dat <= dmem[wb_m.adr[11:2]];
                end
            end else begin
                wait_q <= left - 1;
            end
        end
    end

    // level irq, dropped on the ack pulse
    always @(posedge clk) begin
        if (!reset) begin
            irq     <= 1'b0;
            ack_cnt <= 0;
            cyc_cnt <= 0;
        end else begin
            cyc_cnt <= cyc_cnt + 1;
            if (irq_ack) begin
                irq     <= 1'b0;
                ack_cnt <= ack_cnt + 1;
            end else if (cyc_cnt == irq_at) begin
                irq <= 1'b1;
            end
        end
    end

    task automatic check_idle(string name, inout int errs);
        if (wb_m.cyc !== 1'b0) begin
            $display("error %s: cyc expected 0 actual %b", name, wb_m.cyc);
            errs++;
        end
        if (wb_m.stb !== 1'b0) begin
            $display("error %s: stb expected 0 actual %b", name, wb_m.stb);
            errs++;
        end
        if (irq_ack !== 1'b0) begin
            $display("error %s: irq_ack expected 0 actual %b", name, irq_ack);
            errs++;
        end
        if (pc !== RESET_PC) begin
            $display("error %s: pc expected %h actual %h", name, RESET_PC, pc);
            errs++;
        end
    endtask

    task automatic apply_reset(string name, inout int errs);
        @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle(name, errs);
        end
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_idle(name, errs);
    endtask

    task automatic report(string name, int errs);
        n_tests++;
        n_errs += errs;
        if (errs != 0) n_failed++;
        $display("test %-9s %s", name, (errs == 0) ? "ok" : "failed");
    endtask

    task automatic run_test(string name, int wait_max, int irq_cycle);
        int errs;
        int n_mark;
        errs     = 0;
        max_wait = wait_max;
        irq_at   = irq_cycle;
        n_mark   = (irq_cycle >= 0) ? 1 : 0;
        apply_reset(name, errs);
        while (got_w.size() < exp_w.size()) @(negedge clk);
        // late or stray writes show up here
        repeat (SETTLE) @(negedge clk);
        if (got_w.size() != exp_w.size()) begin
            $display("error %s: write count expected %0d actual %0d", name,
                     exp_w.size(), got_w.size());
            errs++;
        end
        for (int i = 0; i < exp_w.size() && i < got_w.size(); i++) begin
            if (got_w[i] != exp_w[i]) begin
                $display("error %s: write %0d expected %h actual %h", name, i, exp_w[i], got_w[i]);
                errs++;
            end
        end
        if (marker_cnt != n_mark) begin
            $display("error %s: marker writes expected %0d actual %0d", name, n_mark, marker_cnt);
            errs++;
        end
        if (ack_cnt != n_mark) begin
            $display("error %s: irq_ack pulses expected %0d actual %0d", name, n_mark, ack_cnt);
            errs++;
        end
        if (bus_err != 0) begin
            $display("%s: bus signals moved between stb and ack", name);
            errs++;
        end
        if (sel_err != 0) begin
            $display("error %s: sel expected %h actual %h", name, {BUS_SEL_W{1'b1}}, sel_bad);
            errs++;
        end
        report(name, errs);
    endtask

    initial begin
        int errs;
        void'($urandom(SEED));
        for (int i = 0; i < 1024; i++) dinit[i] = $urandom();
        errs = 0;
        apply_reset("reset", errs);
        report("reset", errs);
        // each program runs with short waits, then long ones
        for (int k = 0; k < 3; k++) begin
            gen_program(k);
            run_model();
            run_test(kind_name[k], SHORT_WAIT, -1);
            run_test({kind_name[k], "_bp"}, LONG_WAIT, -1);
        end
        gen_program(3);
        run_model();
        run_test(kind_name[3], SHORT_WAIT, $urandom_range(60, 20));
        $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errs);
        if (n_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // bound from test count and worst cycles per instruction
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                          clk,
    input  wire                          reset,
    input  wire  [rv_isa_pkg::ILEN-1:0]  instr_i,
    input  wire                          irq_i,
    input  wire  rv_bus_pkg::wb_s2m_t    wb_i,
    output logic [rv_isa_pkg::XLEN-1:0]  pc_o,
    output logic                         irq_ack_o,
    output rv_bus_pkg::wb_m2s_t          wb_o
);
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    // ir to decode
    fetch_pkt_t fetch_pkt;
    // decode to execute, same cycle
    decoded_t   dec;
    // execute back to fetch
    redirect_t  redirect;
    logic       stall;
    // execute to data bus unit
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    rv_fetch u_rv_fetch (
        .clk        (clk),
        .reset      (reset),
        .instr_i    (instr_i),
        .redirect_i (redirect),
        .stall_i    (stall),
        .pc_o       (pc_o),
        .fetch_o    (fetch_pkt)
    );

    rv_decode u_rv_decode (
        .fetch_i (fetch_pkt),
        .dec_o   (dec)
    );

    rv_execute u_rv_execute (
        .clk        (clk),
        .reset      (reset),
        .dec_i      (dec),
        .mem_rsp_i  (mem_rsp),
        .irq_i      (irq_i),
        .redirect_o (redirect),
        .stall_o    (stall),
        .mem_req_o  (mem_req),
        .irq_ack_o  (irq_ack_o)
    );

    rv_data_bus u_rv_data_bus (
        .clk       (clk),
        .reset     (reset),
        .mem_req_i (mem_req),
        .wb_i      (wb_i),
        .mem_rsp_o (mem_rsp),
        .wb_o      (wb_o)
    );

endmodule

`default_nettype wire

// File: logic/rv_data_bus.sv
`timescale 1ns/1ps
`default_nettype none

module rv_data_bus (
    input  wire                       clk,
    input  wire                       reset,
    input  wire rv_bus_pkg::mem_req_t mem_req_i,
    input  wire rv_bus_pkg::wb_s2m_t  wb_i,
    output rv_bus_pkg::mem_rsp_t      mem_rsp_o,
    output rv_bus_pkg::wb_m2s_t       wb_o
);
    import rv_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOW,
        ST_HIGH,
        ST_DONE
    } state_e;

    state_e            state_q;
    // cyc and stb always move together
    logic              cyc_q;
    // bus payload, stable while cyc_q is high
    logic              we_q;
    logic [BUS_AW-1:0] adr_q;
    logic [BUS_DW-1:0] dat_q;
    logic [MEM_DW-1:0] rdata_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
            cyc_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (mem_req_i.valid) begin
                    cyc_q   <= 1'b1;
                    state_q <= ST_LOW;
                end
                ST_LOW: if (wb_i.ack) begin
                    // cycle ends, high word if any starts one cycle later
                    cyc_q   <= 1'b0;
                    state_q <= mem_req_i.double ? ST_HIGH : ST_DONE;
                end
                ST_HIGH: begin
                    if (!cyc_q) begin
                        cyc_q <= 1'b1;
                    end else if (wb_i.ack) begin
                        cyc_q   <= 1'b0;
                        state_q <= ST_DONE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && mem_req_i.valid) begin
            adr_q <= mem_req_i.addr;
            dat_q <= mem_req_i.wdata[BUS_DW-1:0];
            we_q  <= mem_req_i.write;
        end
        if (state_q == ST_LOW && wb_i.ack) begin
            // low word first, high word at addr + 4
            rdata_q <= {{BUS_DW{1'b0}}, wb_i.dat};
            adr_q   <= mem_req_i.addr + BUS_AW'(4);
            dat_q   <= mem_req_i.wdata[MEM_DW-1:BUS_DW];
        end
        if (state_q == ST_HIGH && cyc_q && wb_i.ack) begin
            rdata_q[MEM_DW-1:BUS_DW] <= wb_i.dat;
        end
    end

    assign wb_o = '{
        cyc: cyc_q,
        stb: cyc_q,
        we:  we_q,
        adr: adr_q,
        dat: dat_q,
        sel: {BUS_SEL_W{1'b1}}
    };

    // one-cycle pulse, read data valid with it
    assign mem_rsp_o = '{done: (state_q == ST_DONE), rdata: rdata_q};

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire                        clk,
    input  wire                        reset,
    input  wire rv_isa_pkg::decoded_t  dec_i,
    input  wire rv_bus_pkg::mem_rsp_t  mem_rsp_i,
    input  wire                        irq_i,
    output rv_isa_pkg::redirect_t      redirect_o,
    output logic                       stall_o,
    output rv_bus_pkg::mem_req_t       mem_req_o,
    output logic                       irq_ack_o
);
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    // general registers, x0 never written
    logic [XLEN-1:0] rf [0:31];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    // machine csrs touched by trap logic only
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mstatus_q;
    // bus access issued and not yet done
    logic            mem_active_q;
    logic            irq_take;
    logic            wr_en;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] ea;

    assign rs1_val = (dec_i.rs1 == '0) ? '0 : rf[dec_i.rs1];
    assign rs2_val = (dec_i.rs2 == '0) ? '0 : rf[dec_i.rs2];
    assign ea      = rs1_val + dec_i.imm;

    // interrupt replaces the instruction in execute
    // never taken in the middle of a bus access
    assign irq_take = irq_i && mstatus_q[MSTATUS_MIE] && dec_i.valid && !mem_active_q;

    always_comb begin
        result     = '0;
        wr_en      = 1'b0;
        redirect_o = '0;
        mem_req_o  = '0;
        if (irq_take) begin
            redirect_o.valid  = 1'b1;
            redirect_o.target = TRAP_VECTOR;
        end else if (dec_i.valid) begin
            case (dec_i.op)
                OP_LUI:   begin result = dec_i.imm;                 wr_en = 1'b1; end
                OP_AUIPC: begin result = dec_i.pc + dec_i.imm;      wr_en = 1'b1; end
                OP_ADDI:  begin result = ea;                        wr_en = 1'b1; end
                OP_SLLI:  begin result = rs1_val << dec_i.imm[5:0]; wr_en = 1'b1; end
                OP_SRLI:  begin result = rs1_val >> dec_i.imm[5:0]; wr_en = 1'b1; end
                OP_ADD:   begin result = rs1_val + rs2_val;         wr_en = 1'b1; end
                OP_SUB:   begin result = rs1_val - rs2_val;         wr_en = 1'b1; end
                OP_SLT: begin
                    result = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(rs2_val)};
                    wr_en  = 1'b1;
                end
                OP_JAL, OP_JALR: begin
                    // link is the next sequential pc
                    result            = dec_i.pc + XLEN'(4);
                    wr_en             = 1'b1;
                    redirect_o.valid  = 1'b1;
                    redirect_o.target = (dec_i.op == OP_JAL) ? dec_i.pc + dec_i.imm
                                                             : ea & ~XLEN'(1);
                end
                OP_BEQ: begin
                    redirect_o.valid  = (rs1_val == rs2_val);
                    redirect_o.target = dec_i.pc + dec_i.imm;
                end
                OP_LW, OP_LD: begin
                    mem_req_o.valid  = 1'b1;
                    mem_req_o.double = (dec_i.op == OP_LD);
                    mem_req_o.addr   = ea;
                    // lw sign-extends the low word here, not in the bus unit
                    result = (dec_i.op == OP_LD) ? mem_rsp_i.rdata
                           : {{32{mem_rsp_i.rdata[31]}}, mem_rsp_i.rdata[31:0]};
                    wr_en  = mem_rsp_i.done;
                end
                OP_SW, OP_SD: begin
                    mem_req_o.valid  = 1'b1;
                    mem_req_o.write  = 1'b1;
                    mem_req_o.double = (dec_i.op == OP_SD);
                    mem_req_o.addr   = ea;
                    // sw only drives the low half onto the bus
                    mem_req_o.wdata  = rs2_val;
                end
                OP_MRET: begin
                    redirect_o.valid  = 1'b1;
                    redirect_o.target = mepc_q;
                end
                default: wr_en = 1'b0;
            endcase
        end
    end

    // hold pc and ir until the bus unit reports done
    assign stall_o = mem_req_o.valid && !mem_rsp_i.done;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
            mepc_q                 <= '0;
            mcause_q               <= '0;
            mstatus_q              <= '0;
            mstatus_q[MSTATUS_MIE] <= 1'b1;
            mem_active_q           <= 1'b0;
            irq_ack_o              <= 1'b0;
        end else begin
            irq_ack_o    <= irq_take;
            mem_active_q <= mem_req_o.valid && !mem_rsp_i.done;
            if (irq_take) begin
                // return address is the instruction that was skipped
                mepc_q                  <= dec_i.pc;
                mcause_q                <= MCAUSE_MEI;
                mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];
                mstatus_q[MSTATUS_MIE]  <= 1'b0;
            end else if (dec_i.valid && dec_i.op == OP_MRET) begin
                mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
                mstatus_q[MSTATUS_MPIE] <= 1'b1;
            end
            if (wr_en && dec_i.rd != '0) begin
                rf[dec_i.rd] <= result;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire rv_isa_pkg::fetch_pkt_t fetch_i,
    output rv_isa_pkg::decoded_t        dec_o
);
    import rv_isa_pkg::*;

    logic [ILEN-1:0] raw;
    instr_t          ins;
    // immediates for each format, all sign-extended from bit 31
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    op_e             op;
    logic [XLEN-1:0] imm;

    assign raw = fetch_i.instr;
    assign ins = raw;

    assign imm_u = {{32{raw[31]}}, raw[31:12], 12'b0};
    assign imm_i = {{52{raw[31]}}, raw[31:20]};
    assign imm_s = {{52{raw[31]}}, raw[31:25], raw[11:7]};
    // j and b drop bit 0, targets are halfword aligned
    assign imm_j = {{43{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
    assign imm_b = {{51{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};

    always_comb begin
        op  = OP_NOP;
        imm = '0;
        case (ins.opcode)
            OPC_LUI: begin
                op  = OP_LUI;
                imm = imm_u;
            end
            OPC_AUIPC: begin
                op  = OP_AUIPC;
                imm = imm_u;
            end
            OPC_OP_IMM: begin
                // rv64 shifts take funct7[0] as shamt bit 5
                imm = imm_i;
                if (ins.funct3 == F3_ADD) op = OP_ADDI;
                if (ins.funct3 == F3_SLL && ins.funct7[6:1] == 6'b0) op = OP_SLLI;
                if (ins.funct3 == F3_SRL && ins.funct7[6:1] == 6'b0) op = OP_SRLI;
            end
            OPC_OP: begin
                if (ins.funct3 == F3_ADD && ins.funct7 == F7_STD) op = OP_ADD;
                if (ins.funct3 == F3_ADD && ins.funct7 == F7_SUB) op = OP_SUB;
                if (ins.funct3 == F3_SLT && ins.funct7 == F7_STD) op = OP_SLT;
            end
            OPC_JAL: begin
                op  = OP_JAL;
                imm = imm_j;
            end
            OPC_JALR: begin
                imm = imm_i;
                if (ins.funct3 == 3'b000) op = OP_JALR;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                // only beq kept
                if (ins.funct3 == 3'b000) op = OP_BEQ;
            end
            OPC_LOAD: begin
                imm = imm_i;
                if (ins.funct3 == F3_W) op = OP_LW;
                if (ins.funct3 == F3_D) op = OP_LD;
            end
            OPC_STORE: begin
                imm = imm_s;
                if (ins.funct3 == F3_W) op = OP_SW;
                if (ins.funct3 == F3_D) op = OP_SD;
            end
            OPC_SYSTEM: begin
                // no csr access, mret only
                if (raw == MRET_INSTR) op = OP_MRET;
            end
            default: op = OP_NOP;
        endcase
    end

    assign dec_o = '{
        valid: fetch_i.valid,
        op:    op,
        rd:    ins.rd,
        rs1:   ins.rs1,
        rs2:   ins.rs2,
        imm:   imm,
        pc:    fetch_i.pc
    };

endmodule

`default_nettype wire

// File: logic/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [rv_isa_pkg::ILEN-1:0]      instr_i,
    input  wire  rv_isa_pkg::redirect_t      redirect_i,
    input  wire                              stall_i,
    output logic [rv_isa_pkg::XLEN-1:0]      pc_o,
    output rv_isa_pkg::fetch_pkt_t           fetch_o
);
    import rv_isa_pkg::*;

    // fetch address
    logic [XLEN-1:0] pc_q;
    // instruction register and the address it came from
    logic            ir_valid_q;
    logic [XLEN-1:0] ir_pc_q;
    logic [ILEN-1:0] ir_q;

    // pc and ir valid bit
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q       <= RESET_PC;
            ir_valid_q <= 1'b0;
        end else if (redirect_i.valid) begin
            // word on the bus now is from the wrong path
            pc_q       <= redirect_i.target;
            ir_valid_q <= 1'b0;
        end else if (!stall_i) begin
            pc_q       <= pc_q + XLEN'(4);
            ir_valid_q <= 1'b1;
        end
    end

    // ir payload, meaningless while ir_valid_q is low
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ir_q    <= instr_i;
            ir_pc_q <= pc_q;
        end
    end

    // instruction memory answers in the same cycle
    assign pc_o = pc_q;

    assign fetch_o = '{
        valid: ir_valid_q,
        pc:    ir_pc_q,
        instr: ir_q
    };

endmodule

`default_nettype wire

// File: logic/rv_bus_pkg.sv
`default_nettype none

package rv_bus_pkg;

    // wishbone side
    localparam int BUS_DW    = 32;
    localparam int BUS_AW    = 64;
    localparam int BUS_SEL_W = 4;
    // core side carries a whole doubleword
    localparam int MEM_DW    = 2 * BUS_DW;

    // request from execute, held until done
    typedef struct packed {
        logic              valid;
        logic              write;
        logic              double;
        logic [BUS_AW-1:0] addr;
        logic [MEM_DW-1:0] wdata;
    } mem_req_t;

    // single word sits in the low half
    typedef struct packed {
        logic              done;
        logic [MEM_DW-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [BUS_AW-1:0]    adr;
        logic [BUS_DW-1:0]    dat;
        logic [BUS_SEL_W-1:0] sel;
    } wb_m2s_t;

    typedef struct packed {
        logic              ack;
        logic [BUS_DW-1:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // datapath widths
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    // fixed addresses, no mtvec register
    localparam logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_0000_0000;
    localparam logic [XLEN-1:0] TRAP_VECTOR = 64'h0000_0000_0000_0800;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // interrupt flag in msb, cause 11 = machine external
    localparam logic [XLEN-1:0] MCAUSE_MEI = 64'h8000_0000_0000_000B;

    // full mret encoding, no fields vary
    localparam logic [ILEN-1:0] MRET_INSTR = 32'h3020_0073;

    // funct3 / funct7 values of the kept instructions
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_W   = 3'b010;
    localparam logic [2:0] F3_D   = 3'b011;
    localparam logic [6:0] F7_STD = 7'b000_0000;
    localparam logic [6:0] F7_SUB = 7'b010_0000;

    // major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_OP_IMM = 7'b001_0011,
        OPC_OP     = 7'b011_0011,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011,
        OPC_SYSTEM = 7'b111_0011
    } opcode_e;

    // executed operations, anything unmatched becomes OP_NOP
    typedef enum logic [4:0] {
        OP_NOP, OP_LUI, OP_AUIPC, OP_ADDI, OP_SLLI, OP_SRLI,
        OP_ADD, OP_SUB, OP_SLT, OP_JAL, OP_JALR, OP_BEQ,
        OP_LW, OP_LD, OP_SW, OP_SD, OP_MRET
    } op_e;

    // r-type field layout, other formats reuse the same slots
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  valid;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire
